// ==== common/cpu_config_pkg.sv ====
`default_nettype none

package cpu_config_pkg;

  // integer datapath width, rv64
  localparam int xlen = 64;

  // architectural integer registers
  localparam int reg_count = 32;
  localparam int reg_idx_w = 5;

  // rv64 shifts use six bits of the shift operand
  localparam int shamt_w = 6;

  // one register value
  typedef logic [xlen-1:0] xdata_t;

  // register number, x0 .. x31
  typedef logic [reg_idx_w-1:0] reg_idx_t;

endpackage

`default_nettype wire

// ==== common/exec_types_pkg.sv ====
`default_nettype none

package exec_types_pkg;
  import cpu_config_pkg::*;

  // integer alu operations
  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,
    op_sll  = 4'd5,
    op_srl  = 4'd6,
    op_sra  = 4'd7,
    op_slt  = 4'd8,
    op_sltu = 4'd9
  } alu_op_e;

  // one instruction as it arrives in an issue slot
  typedef struct packed {
    logic     valid;
    alu_op_e  op;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    xdata_t   imm;
    logic     use_imm; // b operand from imm instead of rs2
  } issue_slot_t;

  // resolved operands handed to a lane
  typedef struct packed {
    logic     valid;
    alu_op_e  op;
    reg_idx_t rd;
    xdata_t   a;
    xdata_t   b;
  } lane_in_t;

  // lane output, also used for retirement
  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    xdata_t   data;
  } result_t;

endpackage

`default_nettype wire

// ==== int_lane/int_lane.sv ====
`timescale 1ns/100ps
`default_nettype none

module int_lane (
  input  logic                     clock,
  input  logic                     rst,
  input  exec_types_pkg::lane_in_t lane_in,
  output exec_types_pkg::result_t  res
);
  import cpu_config_pkg::*;
  import exec_types_pkg::*;

  xdata_t             alu_result;
  logic [shamt_w-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;

  assign shamt       = lane_in.b[shamt_w-1:0]; // upper bits of b ignored
  assign lt_signed   = $signed(lane_in.a) < $signed(lane_in.b);
  assign lt_unsigned = lane_in.a < lane_in.b;

  always_comb begin
    case (lane_in.op)
      op_add: begin
        alu_result = lane_in.a + lane_in.b;
      end
      op_sub: begin
        alu_result = lane_in.a - lane_in.b;
      end
      op_and: begin
        alu_result = lane_in.a & lane_in.b;
      end
      op_or: begin
        alu_result = lane_in.a | lane_in.b;
      end
      op_xor: begin
        alu_result = lane_in.a ^ lane_in.b;
      end
      op_sll: begin
        alu_result = lane_in.a << shamt;
      end
      op_srl: begin
        alu_result = lane_in.a >> shamt;
      end
      op_sra: begin
        alu_result = $signed(lane_in.a) >>> shamt; // sign fill
      end
      op_slt: begin
        alu_result = {{(xlen-1){1'b0}}, lt_signed};
      end
      op_sltu: begin
        alu_result = {{(xlen-1){1'b0}}, lt_unsigned};
      end
      default: begin
        alu_result = '0;
      end
    endcase
  end

  // result register, one cycle through the lane
  always_ff @(posedge clock) begin
    res.rd   <= lane_in.rd;
    res.data <= alu_result;
    if (rst) begin
      res.valid <= 1'b0;
    end else begin
      res.valid <= lane_in.valid;
    end
  end

  // the register file must only hand over known operations
  op_defined: assert property (
    @(posedge clock) disable iff (rst)
    lane_in.valid |-> lane_in.op inside {op_add, op_sub, op_and, op_or, op_xor,
                                         op_sll, op_srl, op_sra, op_slt, op_sltu}
  ) else $error("int_lane: undefined alu op %0d", lane_in.op);

endmodule

`default_nettype wire

// ==== register_file/register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module register_file (
  input  logic                        clock,
  input  logic                        rst,
  input  exec_types_pkg::issue_slot_t slot0,
  input  exec_types_pkg::issue_slot_t slot1,
  input  exec_types_pkg::result_t     lane0_res,
  input  exec_types_pkg::result_t     lane1_res,
  output exec_types_pkg::lane_in_t    lane0_in,
  output exec_types_pkg::lane_in_t    lane1_in,
  output exec_types_pkg::result_t     retire0,
  output exec_types_pkg::result_t     retire1
);
  import cpu_config_pkg::*;
  import exec_types_pkg::*;

  xdata_t regs [reg_count];

  logic wr0;
  logic wr1;
  logic wr0_shadowed;

  // architectural value of one source with bypass from the lane registers
  function automatic xdata_t read_operand(input reg_idx_t idx);
    xdata_t value;
    if (idx == '0) begin
      value = '0;
    end else if (lane1_res.valid && lane1_res.rd == idx) begin
      value = lane1_res.data; // younger of the pair wins
    end else if (lane0_res.valid && lane0_res.rd == idx) begin
      value = lane0_res.data;
    end else begin
      value = regs[idx];
    end
    return value;
  endfunction

  function automatic lane_in_t build_lane(input issue_slot_t slot);
    lane_in_t li;
    li.valid = slot.valid;
    li.op    = slot.op;
    li.rd    = slot.rd;
    li.a     = read_operand(slot.rs1);
    li.b     = slot.use_imm ? slot.imm : read_operand(slot.rs2);
    return li;
  endfunction

  // both slots see state from before the pair
  always_comb begin
    lane0_in = build_lane(slot0);
    lane1_in = build_lane(slot1);
  end

  assign wr0          = lane0_res.valid && (lane0_res.rd != '0);
  assign wr1          = lane1_res.valid && (lane1_res.rd != '0);
  assign wr0_shadowed = wr1 && (lane1_res.rd == lane0_res.rd);

  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wr0 && !wr0_shadowed) begin
        regs[lane0_res.rd] <= lane0_res.data;
      end
      if (wr1) begin
        regs[lane1_res.rd] <= lane1_res.data;
      end
    end
  end

  // retirement mirrors the writeback even for x0
  always_ff @(posedge clock) begin
    retire0.rd   <= lane0_res.rd;
    retire0.data <= lane0_res.data;
    retire1.rd   <= lane1_res.rd;
    retire1.data <= lane1_res.data;
    if (rst) begin
      retire0.valid <= 1'b0;
      retire1.valid <= 1'b0;
    end else begin
      retire0.valid <= lane0_res.valid;
      retire1.valid <= lane1_res.valid;
    end
  end

  x0_zero: assert property (
    @(posedge clock) disable iff (rst)
    regs[0] == '0
  ) else $error("register_file: x0 holds %h", regs[0]);

  // nothing retires on the edge after reset release
  retire_quiet_after_rst: assert property (
    @(posedge clock) $fell(rst) |=> !retire0.valid && !retire1.valid
  ) else $error("register_file: retire valid right after reset");

endmodule

`default_nettype wire

// ==== hdl/exec_cluster.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_cluster (
  input  logic                        clock,
  input  logic                        rst,
  input  exec_types_pkg::issue_slot_t slot0,
  input  exec_types_pkg::issue_slot_t slot1,
  output exec_types_pkg::result_t     retire0,
  output exec_types_pkg::result_t     retire1
);
  import exec_types_pkg::*;

  lane_in_t lane0_in;
  lane_in_t lane1_in;
  result_t  lane0_res;
  result_t  lane1_res;

  // operand read, writeback and retirement
  register_file regs (
    .clock     (clock),
    .rst       (rst),
    .slot0     (slot0),
    .slot1     (slot1),
    .lane0_res (lane0_res),
    .lane1_res (lane1_res),
    .lane0_in  (lane0_in),
    .lane1_in  (lane1_in),
    .retire0   (retire0),
    .retire1   (retire1)
  );

  // older slot
  int_lane lane0 (
    .clock   (clock),
    .rst     (rst),
    .lane_in (lane0_in),
    .res     (lane0_res)
  );

  int_lane lane1 (
    .clock   (clock),
    .rst     (rst),
    .lane_in (lane1_in),
    .res     (lane1_res)
  );

endmodule

`default_nettype wire

// ==== dv/tb_exec_cluster.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_exec_cluster;
  import cpu_config_pkg::*;
  import exec_types_pkg::*;

  localparam int rand_pairs = 400;
  localparam int wait_limit = 50;

  logic        clock;
  logic        rst;
  issue_slot_t slot0;
  issue_slot_t slot1;
  result_t     retire0;
  result_t     retire1;

  int      seed;
  int      errors;
  int      checks;
  logic    checking;
  xdata_t  mregs [reg_count]; // architectural state as the model sees it
  result_t exp_q0 [$];
  result_t exp_q1 [$];

  exec_cluster uut (
    .clock   (clock),
    .rst     (rst),
    .slot0   (slot0),
    .slot1   (slot1),
    .retire0 (retire0),
    .retire1 (retire1)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clock);
    rst <= 1'b0;
  end

  // expected alu result, written from the rv64 definitions
  function automatic xdata_t alu_ref(input alu_op_e op, input xdata_t a, input xdata_t b);
    logic [shamt_w-1:0] sh;
    xdata_t             r;
    sh = b[shamt_w-1:0];
    r  = '0;
    case (op)
      op_add:  r = a + b;
      op_sub:  r = a + ~b + 64'd1;
      op_and:  r = a & b;
      op_or:   r = a | b;
      op_xor:  r = a ^ b;
      op_sll:  r = a << sh;
      op_srl:  r = a >> sh;
      op_sra:  r = (a >> sh) | (a[xlen-1] ? ~({xlen{1'b1}} >> sh) : '0);
      op_slt: begin
        if (a[xlen-1] != b[xlen-1]) begin
          r[0] = a[xlen-1]; // negative one is smaller
        end else begin
          r[0] = a < b;
        end
      end
      op_sltu: r[0] = a < b;
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic issue_slot_t reg_slot(input alu_op_e op, input reg_idx_t rd,
                                           input reg_idx_t rs1, input reg_idx_t rs2);
    issue_slot_t s;
    s       = '0;
    s.valid = 1'b1;
    s.op    = op;
    s.rd    = rd;
    s.rs1   = rs1;
    s.rs2   = rs2;
    return s;
  endfunction

  function automatic issue_slot_t imm_slot(input alu_op_e op, input reg_idx_t rd,
                                           input reg_idx_t rs1, input xdata_t imm);
    issue_slot_t s;
    s         = '0;
    s.valid   = 1'b1;
    s.op      = op;
    s.rd      = rd;
    s.rs1     = rs1;
    s.imm     = imm;
    s.use_imm = 1'b1;
    return s;
  endfunction

  function automatic issue_slot_t idle_slot();
    issue_slot_t s;
    s = '0;
    return s;
  endfunction

  // registers limited to x0..x15 so pairs collide often
  function automatic issue_slot_t random_slot();
    issue_slot_t s;
    logic [31:0] r;
    logic [31:0] hi;
    logic [31:0] lo;
    r         = $random(seed);
    hi        = $random(seed);
    lo        = $random(seed);
    s.valid   = (r[3:0] != 4'd0);
    s.op      = alu_op_e'(4'(r[15:8] % 8'd10));
    s.rs1     = {1'b0, r[19:16]};
    s.rs2     = {1'b0, r[23:20]};
    s.rd      = {1'b0, r[27:24]};
    s.use_imm = r[28];
    s.imm     = {hi, lo};
    return s;
  endfunction

  // drive one pair and push what each lane should retire
  task automatic drive_pair(input issue_slot_t s0, input issue_slot_t s1);
    xdata_t  a0;
    xdata_t  b0;
    xdata_t  a1;
    xdata_t  b1;
    result_t e0;
    result_t e1;
    @(posedge clock);
    slot0 <= s0;
    slot1 <= s1;
    a0 = mregs[s0.rs1]; // both reads before either write
    b0 = s0.use_imm ? s0.imm : mregs[s0.rs2];
    a1 = mregs[s1.rs1];
    b1 = s1.use_imm ? s1.imm : mregs[s1.rs2];
    e0.valid = s0.valid;
    e0.rd    = s0.rd;
    e0.data  = alu_ref(s0.op, a0, b0);
    e1.valid = s1.valid;
    e1.rd    = s1.rd;
    e1.data  = alu_ref(s1.op, a1, b1);
    if (e0.valid && e0.rd != '0) begin
      mregs[e0.rd] = e0.data;
    end
    if (e1.valid && e1.rd != '0) begin
      mregs[e1.rd] = e1.data; // slot 1 lands last
    end
    exp_q0.push_back(e0);
    exp_q1.push_back(e1);
  endtask

  task automatic check_retire(input int lane, input result_t got, input result_t exp);
    checks++;
    assert (got.valid == exp.valid) else begin
      errors++;
      $display("[ERROR] %0t: retire%0d valid %b, expected %b",
               $time, lane, got.valid, exp.valid);
    end
    if (exp.valid) begin
      assert (got.rd == exp.rd && got.data == exp.data) else begin
        errors++;
        $display("[ERROR] %0t: retire%0d rd %0d data %h, expected rd %0d data %h",
                 $time, lane, got.rd, got.data, exp.rd, exp.data);
      end
    end
  endtask

  task automatic check_idle();
    checks++;
    assert (retire0.valid == 1'b0 && retire1.valid == 1'b0) else begin
      errors++;
      $display("[ERROR] %0t: retire valid with nothing in flight", $time);
    end
  endtask

  // a pair driven at edge t is due after edge t+2
  always @(negedge clock) begin
    result_t e0;
    result_t e1;
    if (checking) begin
      if (exp_q0.size() >= 3) begin
        e0 = exp_q0.pop_front();
        e1 = exp_q1.pop_front();
        check_retire(0, retire0, e0);
        check_retire(1, retire1, e1);
      end else begin
        check_idle();
      end
    end
  end

  task automatic run_tests();
    issue_slot_t s0;
    issue_slot_t s1;
    repeat (3) drive_pair(idle_slot(), idle_slot());
    // fresh registers read zero
    drive_pair(reg_slot(op_or, 5'd8, 5'd3, 5'd9), reg_slot(op_add, 5'd9, 5'd31, 5'd17));

    // dependency chain, forwarded then from the array
    drive_pair(imm_slot(op_add, 5'd1, 5'd0, 64'h0123_4567_89ab_cdef),
               imm_slot(op_add, 5'd2, 5'd0, 64'hfedc_ba98_7654_3210));
    drive_pair(reg_slot(op_add, 5'd3, 5'd1, 5'd2), reg_slot(op_xor, 5'd4, 5'd2, 5'd1));
    drive_pair(reg_slot(op_sub, 5'd5, 5'd1, 5'd3), reg_slot(op_and, 5'd6, 5'd4, 5'd2));

    // same pair, slot 1 sees the old x10
    drive_pair(imm_slot(op_add, 5'd10, 5'd0, 64'h55), reg_slot(op_or, 5'd11, 5'd10, 5'd0));
    drive_pair(imm_slot(op_add, 5'd12, 5'd0, 64'h111), imm_slot(op_add, 5'd12, 5'd0, 64'h222));
    drive_pair(reg_slot(op_add, 5'd13, 5'd12, 5'd0), idle_slot());
    drive_pair(idle_slot(), idle_slot());
    drive_pair(idle_slot(), reg_slot(op_add, 5'd14, 5'd12, 5'd0));

    // x0 as destination
    drive_pair(imm_slot(op_add, 5'd0, 5'd1, 64'h77), reg_slot(op_add, 5'd15, 5'd0, 5'd1));
    drive_pair(reg_slot(op_or, 5'd16, 5'd0, 5'd0), imm_slot(op_add, 5'd0, 5'd0, 64'h5));
    drive_pair(reg_slot(op_add, 5'd17, 5'd0, 5'd2), idle_slot());

    repeat (4) drive_pair(idle_slot(), idle_slot());

    for (int n = 0; n < rand_pairs; n++) begin
      s0       = random_slot();
      s1       = random_slot();
      s0.valid = 1'b1;
      s0.op    = alu_op_e'(4'(n % 10)); // walk through every op
      drive_pair(s0, s1);
    end
    repeat (2) drive_pair(idle_slot(), idle_slot());
  endtask

  initial begin
    int n;
    seed     = 32'h3dc9bad1;
    errors   = 0;
    checks   = 0;
    checking = 1'b0;
    slot0    = '0;
    slot1    = '0;
    for (int i = 0; i < reg_count; i++) begin
      mregs[i] = '0;
    end

    for (n = 0; n < wait_limit && rst !== 1'b0; n++) begin
      @(posedge clock);
    end
    if (rst !== 1'b0) begin
      errors++;
      $display("reset was never released");
    end else begin
      checking = 1'b1;
      run_tests();
      for (n = 0; n < wait_limit && exp_q0.size() > 2; n++) begin
        @(negedge clock);
      end
      if (exp_q0.size() > 2) begin
        errors++;
        $display("timed out waiting for the last results to retire");
      end
      repeat (3) @(negedge clock);
    end

    $display("tb_exec_cluster: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
common/cpu_config_pkg.sv
common/exec_types_pkg.sv
int_lane/int_lane.sv
register_file/register_file.sv
hdl/exec_cluster.sv
dv/tb_exec_cluster.sv

// ==== Makefile ====
TOP = tb_exec_cluster

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  --top-module $(TOP) -Mdir obj_dir -f build.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
